//--- csr_index_generator.f
src/csr_index_pkg.sv
src/csr_index_sequencer.sv
src/csr_request_former.sv
src/csr_request_fifo.sv
src/csr_index_generator.sv
test/csr_index_generator_tb.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := csr_index_generator_tb
FILELIST  := csr_index_generator.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/csr_index_generator_tb.sv
`timescale 1ns/1ns

module csr_index_generator_tb import csr_index_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int SETUP_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 3000;
    localparam int HOLD_CYCLES   = 100;
    localparam int QUIET_CYCLES  = 20;

    logic              ap_clk;
    logic              areset_generator;
    logic              descriptor_valid;
    csr_index_config_t config_in;
    logic              request_rd_en;
    logic              config_setup;
    memory_request_t   request_out;
    logic              done;

    memory_request_t expected_q[$];
    string           test_name;
    int              rx_count;
    int              check_errors;
    int              tests_run;
    int              tests_failed;
    bit              count_writes;
    int              write_count;

    csr_index_generator csr_index_generator_inst (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid),
        .config_in        (config_in),
        .request_rd_en    (request_rd_en),
        .config_setup     (config_setup),
        .request_out      (request_out),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // Once high, done holds until the next reset
    property done_holds;
        @(posedge ap_clk) disable iff (areset_generator) done |=> done;
    endproperty

    done_hold_check: assert property (done_holds)
        else begin
            $display("done fell without a reset in test %s", test_name);
            check_errors++;
        end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic report_mismatch(input string what, input logic [63:0] expected_value,
                                   input logic [63:0] actual_value);
        $display("ERR %s %s: expected 0x%0h, actual 0x%0h",
                 test_name, what, expected_value, actual_value);
        check_errors++;
    endtask

    // Indices from start in steps of stride while below end
    function automatic void build_expected(input csr_index_config_t cfg);
        logic [63:0]     idx;
        memory_request_t req;
        expected_q.delete();
        idx = 64'(cfg.index_start);
        while (idx < 64'(cfg.index_end)) begin
            req.valid = 1'b1;
            req.base  = cfg.array_pointer;
            req.index = index_t'(idx);
            if (cfg.shift_left) begin
                req.offset = index_t'(idx << cfg.shift_amount);
            end else begin
                req.offset = index_t'(idx >> cfg.shift_amount);
            end
            expected_q.push_back(req);
            idx = idx + 64'(cfg.stride);
        end
    endfunction

    task automatic apply_reset();
        areset_generator = 1'b1;
        descriptor_valid = 1'b0;
        config_in        = '0;
        request_rd_en    = 1'b0;
        repeat (3) @(posedge ap_clk);
        #DRIVE_DELAY;
        areset_generator = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        check_errors = 0;
        rx_count     = 0;
        expected_q.delete();
        apply_reset();
    endtask

    task automatic start_run(input csr_index_config_t cfg);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge ap_clk);
        #DRIVE_DELAY;
        descriptor_valid = 1'b1;
        @(posedge ap_clk);
        #DRIVE_DELAY;
        descriptor_valid = 1'b0;
        while (!seen && cycles < SETUP_TIMEOUT) begin
            @(negedge ap_clk);
            seen = config_setup;
            cycles++;
        end
        if (!seen) begin
            $display("config_setup never pulsed in test %s", test_name);
            check_errors++;
        end
        @(posedge ap_clk);
        #DRIVE_DELAY;
        config_in       = cfg;
        config_in.valid = 1'b1;
        @(posedge ap_clk);
        #DRIVE_DELAY;
        config_in.valid = 1'b0;
    endtask

    // Runs until done and every expected request has arrived
    task automatic wait_for_drain(input bit random_rd);
        int cycles;
        bit finished;
        cycles   = 0;
        finished = 1'b0;
        while (!finished && cycles < DRAIN_TIMEOUT) begin
            @(posedge ap_clk);
            #DRIVE_DELAY;
            if (random_rd) begin
                request_rd_en = 1'($urandom_range(0, 1));
            end
            finished = done && (rx_count >= expected_q.size());
            cycles++;
        end
        if (!finished) begin
            $display("Timed out waiting for done and %0d requests in test %s, got %0d",
                     expected_q.size(), test_name, rx_count);
            check_errors++;
        end
        request_rd_en = 1'b1;
        // Window for any request beyond the expected list
        repeat (QUIET_CYCLES) @(posedge ap_clk);
    endtask

    task automatic end_test();
        count_check: assert (rx_count == expected_q.size())
            else report_mismatch("request count", 64'(expected_q.size()), 64'(rx_count));
        @(negedge ap_clk);
        done_check: assert (done)
            else begin
                $display("done is not high at the end of test %s", test_name);
                check_errors++;
            end
        tests_run++;
        if (check_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, check_errors);
        end
    endtask

    task automatic run_directed(input string name, input csr_index_config_t cfg);
        begin_test(name);
        build_expected(cfg);
        request_rd_en = 1'b1;
        start_run(cfg);
        wait_for_drain(1'b0);
        end_test();
    endtask

    // ----------------------------------------
    // Collector and write monitor
    // ----------------------------------------
    always @(negedge ap_clk) begin
        if (!areset_generator && request_out.valid) begin
            if (rx_count < expected_q.size()) begin
                base_check: assert (request_out.base == expected_q[rx_count].base)
                    else report_mismatch($sformatf("request %0d base", rx_count),
                                         64'(expected_q[rx_count].base), 64'(request_out.base));
                offset_check: assert (request_out.offset == expected_q[rx_count].offset)
                    else report_mismatch($sformatf("request %0d offset", rx_count),
                                         64'(expected_q[rx_count].offset),
                                         64'(request_out.offset));
                index_check: assert (request_out.index == expected_q[rx_count].index)
                    else report_mismatch($sformatf("request %0d index", rx_count),
                                         64'(expected_q[rx_count].index),
                                         64'(request_out.index));
            end else begin
                $display("Unexpected request with index 0x%0h in test %s",
                         request_out.index, test_name);
                check_errors++;
            end
            rx_count++;
        end
    end

    always @(negedge ap_clk) begin
        if (count_writes && csr_index_generator_inst.write_entry.valid) begin
            write_count++;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int                seed_value;
        csr_index_config_t cfg;
        seed_value       = $urandom(37);
        areset_generator = 1'b1;
        descriptor_valid = 1'b0;
        config_in        = '0;
        request_rd_en    = 1'b0;
        tests_run        = 0;
        tests_failed     = 0;
        count_writes     = 1'b0;
        write_count      = 0;
        rx_count         = 0;
        check_errors     = 0;

        // Quiet outputs with no descriptor
        begin_test("reset_state");
        repeat (QUIET_CYCLES) begin
            @(negedge ap_clk);
            idle_check: assert (!done && !config_setup && !request_out.valid)
                else begin
                    $display("Output active after reset in test %s", test_name);
                    check_errors++;
                end
        end
        tests_run++;
        if (check_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, check_errors);
        end

        cfg               = '0;
        cfg.array_pointer = $urandom;
        cfg.index_start   = 32'd5;
        cfg.index_end     = 32'd17;
        cfg.stride        = 32'd1;
        cfg.shift_left    = 1'b1;
        cfg.shift_amount  = 5'd2;
        run_directed("unit_stride_left", cfg);

        cfg.array_pointer = $urandom;
        cfg.index_start   = 32'd3;
        cfg.index_end     = 32'd40;
        cfg.stride        = 32'd7;
        cfg.shift_left    = 1'b0;
        cfg.shift_amount  = 5'd1;
        run_directed("stride_right", cfg);

        cfg.index_start = 32'd20;
        cfg.index_end   = 32'd20;
        cfg.stride      = 32'd1;
        run_directed("empty_range", cfg);

        // Reader stalled until the FIFO fills and generation pauses
        cfg.array_pointer = $urandom;
        cfg.index_start   = 32'd100;
        cfg.index_end     = 32'd150;
        cfg.stride        = 32'd1;
        cfg.shift_left    = 1'b1;
        cfg.shift_amount  = 5'd3;
        begin_test("back_pressure");
        build_expected(cfg);
        write_count  = 0;
        count_writes = 1'b1;
        start_run(cfg);
        repeat (HOLD_CYCLES) @(posedge ap_clk);
        count_writes = 1'b0;
        held_writes_check: assert (write_count <= FIFO_DEPTH)
            else report_mismatch("writes while stalled", 64'(FIFO_DEPTH), 64'(write_count));
        held_rx_check: assert (rx_count == 0)
            else report_mismatch("requests while stalled", 64'd0, 64'(rx_count));
        wait_for_drain(1'b1);
        end_test();

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : csr_index_generator_tb

//--- src/csr_index_generator.sv
`timescale 1ns/1ns

module csr_index_generator import csr_index_pkg::*; (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              descriptor_valid,
    input  csr_index_config_t config_in,
    input  logic              request_rd_en,
    output logic              config_setup,
    output memory_request_t   request_out,
    output logic              done
);

    logic              descriptor_valid_reg;
    logic              config_valid_reg;
    csr_index_config_t config_payload_reg;
    csr_index_config_t config_reg;
    logic              request_rd_en_reg;

    csr_index_config_t active_config;
    logic              index_valid;
    index_t            index;
    memory_request_t   write_entry;
    logic              prog_full;

    // ----------------------------------------
    // Input registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            descriptor_valid_reg <= 1'b0;
            config_valid_reg     <= 1'b0;
            request_rd_en_reg    <= 1'b0;
        end else begin
            descriptor_valid_reg <= descriptor_valid;
            config_valid_reg     <= config_in.valid;
            request_rd_en_reg    <= request_rd_en;
        end
    end

    always_ff @(posedge ap_clk) begin
        config_payload_reg <= config_in;
    end

    always_comb begin
        config_reg       = config_payload_reg;
        config_reg.valid = config_valid_reg;
    end

    // ----------------------------------------
    // Blocks
    // ----------------------------------------
    csr_index_sequencer csr_index_sequencer_inst (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid_reg),
        .config_in        (config_reg),
        .prog_full        (prog_full),
        .config_setup     (config_setup),
        .active_config    (active_config),
        .index_valid      (index_valid),
        .index            (index),
        .done             (done)
    );

    csr_request_former csr_request_former_inst (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .index_valid      (index_valid),
        .index            (index),
        .active_config    (active_config),
        .write_entry      (write_entry)
    );

    // Empty check lives inside the FIFO
    csr_request_fifo csr_request_fifo_inst (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .write_entry      (write_entry),
        .rd_en            (request_rd_en_reg),
        .read_entry       (request_out),
        .prog_full        (prog_full)
    );

endmodule : csr_index_generator

//--- src/csr_request_fifo.sv
`timescale 1ns/1ns

module csr_request_fifo import csr_index_pkg::*; (
    input  logic            ap_clk,
    input  logic            areset_generator,
    input  memory_request_t write_entry,
    input  logic            rd_en,
    output memory_request_t read_entry,
    output logic            prog_full
);

    memory_request_t mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   occupancy;

    logic            empty;
    logic            full;
    logic            push;
    logic            pop;
    logic            read_valid;
    memory_request_t read_payload;

    assign empty = (occupancy == '0);
    assign full  = (occupancy == (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign push  = write_entry.valid & ~full;
    assign pop   = rd_en & ~empty;

    assign prog_full = (occupancy >= (FIFO_PTR_W+1)'(PROG_THRESH));

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occupancy  <= '0;
            read_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
            read_valid <= pop;
        end
    end

    // ----------------------------------------
    // Storage and read register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= write_entry;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            read_payload <= mem[rd_ptr];
        end
    end

    // Entry is presented the cycle after the pop
    always_comb begin
        read_entry       = read_payload;
        read_entry.valid = read_valid;
    end

endmodule : csr_request_fifo

//--- src/csr_request_former.sv
`timescale 1ns/1ns

module csr_request_former import csr_index_pkg::*; (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              index_valid,
    input  index_t            index,
    input  csr_index_config_t active_config,
    output memory_request_t   write_entry
);

    logic            entry_valid;
    memory_request_t entry_payload;
    index_t          offset;

    // Bits shifted out either way are lost
    always_comb begin
        if (active_config.shift_left) begin
            offset = index << active_config.shift_amount;
        end else begin
            offset = index >> active_config.shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            entry_valid <= 1'b0;
        end else begin
            entry_valid <= index_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (index_valid) begin
            entry_payload.valid  <= 1'b1;
            entry_payload.base   <= active_config.array_pointer;
            entry_payload.offset <= offset;
            entry_payload.index  <= index;
        end
    end

    // Valid field doubles as the FIFO write enable
    always_comb begin
        write_entry       = entry_payload;
        write_entry.valid = entry_valid;
    end

endmodule : csr_request_former

//--- src/csr_index_sequencer.sv
`timescale 1ns/1ns

module csr_index_sequencer import csr_index_pkg::*; (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              descriptor_valid,
    input  csr_index_config_t config_in,
    input  logic              prog_full,
    output logic              config_setup,
    output csr_index_config_t active_config,
    output logic              index_valid,
    output index_t            index,
    output logic              done
);

    index_gen_state_t state;
    index_gen_state_t next_state;

    index_t count;
    index_t count_next;
    logic   count_carry;
    logic   count_wrap;
    logic   range_end;
    logic   advance;

    // ----------------------------------------
    // Counter arithmetic
    // ----------------------------------------
    assign {count_carry, count_next} = {1'b0, count} + {1'b0, active_config.stride};

    // A wrapped counter is past any end value
    assign range_end = count_wrap | (count >= active_config.index_end);

    // One index per cycle while running and below the FIFO threshold
    assign advance = (state == BUSY) & ~range_end & ~prog_full;

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (descriptor_valid) begin
                    next_state = SETUP;
                end
            end
            SETUP: begin
                next_state = WAIT_CONFIG;
            end
            WAIT_CONFIG: begin
                if (config_in.valid) begin
                    next_state = START;
                end
            end
            START: begin
                next_state = BUSY;
            end
            BUSY: begin
                // Empty range lands here right after START
                if (range_end) begin
                    next_state = DONE;
                end else if (prog_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (~prog_full) begin
                    next_state = BUSY;
                end
            end
            DONE: begin
                next_state = DONE;
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // ----------------------------------------
    // Control outputs
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_setup <= 1'b0;
            index_valid  <= 1'b0;
            done         <= 1'b0;
            count_wrap   <= 1'b0;
        end else begin
            config_setup <= (state == SETUP);
            index_valid  <= advance;
            done         <= (next_state == DONE);
            if (state == START) begin
                count_wrap <= 1'b0;
            end else if (advance) begin
                count_wrap <= count_wrap | count_carry;
            end
        end
    end

    // Configuration held for the whole run
    always_ff @(posedge ap_clk) begin
        if ((state == WAIT_CONFIG) && config_in.valid) begin
            active_config <= config_in;
        end
    end

    // Index counter and strobed index
    always_ff @(posedge ap_clk) begin
        if (state == START) begin
            count <= active_config.index_start;
        end else if (advance) begin
            count <= count_next;
        end
        if (advance) begin
            index <= count;
        end
    end

endmodule : csr_index_sequencer

//--- src/csr_index_pkg.sv
package csr_index_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int INDEX_W = 32;
    localparam int ADDR_W  = 32;
    localparam int SHIFT_W = 5;

    // ----------------------------------------
    // Request FIFO sizing
    // ----------------------------------------
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Leaves headroom for the requests still in the pipe when a pause starts
    localparam int PROG_THRESH = 8;

    // Vertex or edge index, also the request offset
    typedef logic [INDEX_W-1:0] index_t;

    // Array base pointer
    typedef logic [ADDR_W-1:0] addr_t;

    // Offset shift amount
    typedef logic [SHIFT_W-1:0] shift_t;

    // Sequencer states
    typedef enum logic [2:0] {
        RESET,
        IDLE,
        SETUP,
        WAIT_CONFIG,
        START,
        BUSY,
        PAUSE,
        DONE
    } index_gen_state_t;

    // One run of the generator
    typedef struct packed {
        logic   valid;
        addr_t  array_pointer;
        index_t index_start;
        index_t index_end;
        index_t stride;
        logic   shift_left;
        shift_t shift_amount;
    } csr_index_config_t;

    // Memory request, base plus shifted offset, raw index as data
    typedef struct packed {
        logic   valid;
        addr_t  base;
        index_t offset;
        index_t index;
    } memory_request_t;

endpackage : csr_index_pkg
